// File: all.f
common/spawnout_pkg.sv
verilog/spawn_decode.sv
spawn_writer/spawn_queue_writer.sv
verilog/spawn_result.sv
verilog/spawn_queue_ram.sv
verilog/spawnout_top.sv
verification/tb_clock_gen.sv
verification/spawnout_properties.sv
verification/spawnout_tb.sv

// File: common/spawnout_pkg.sv
// Slot layout, queue word views and return codes; the slot count must stay a power of two
`default_nettype none

package spawnout_pkg;

    // Queue geometry
    localparam int queue_slots     = 64;
    localparam int slot_words      = 16;
    localparam int queue_words     = queue_slots * slot_words;
    localparam int word_bytes      = 8;
    localparam int slot_bytes      = slot_words * word_bytes;
    localparam int slot_idx_bits   = $clog2(queue_slots);
    localparam int queue_idx_bits  = $clog2(queue_words);
    localparam int max_payload     = 12;

    // Request field widths
    localparam int tasktype_bits   = 32;
    localparam int archbits_bits   = 2;

    // Word numbers inside a slot, payload runs up to the end of the slot
    localparam logic [3:0] word_header    = 4'd0;
    localparam logic [3:0] word_task_id   = 4'd1;
    localparam logic [3:0] word_parent_id = 4'd2;
    localparam logic [3:0] word_type      = 4'd3;
    localparam logic [3:0] word_payload   = 4'd4;

    // Return codes seen by the scheduler
    localparam logic [1:0] ret_wait   = 2'd0;
    localparam logic [1:0] ret_ok     = 2'd1;
    localparam logic [1:0] ret_reject = 2'd2;

    // Writer FSM encoding
    localparam logic [2:0] st_idle       = 3'd0;
    localparam logic [2:0] st_check_read = 3'd1;
    localparam logic [2:0] st_check      = 3'd2;
    localparam logic [2:0] st_payload    = 3'd3;
    localparam logic [2:0] st_task_id    = 3'd4;
    localparam logic [2:0] st_parent_id  = 3'd5;
    localparam logic [2:0] st_type       = 3'd6;
    localparam logic [2:0] st_header     = 3'd7;

    // Word 0 of a slot, valid set means the consumer still owns it
    typedef struct packed {
        logic        valid;
        logic [30:0] reserved;
        logic [7:0]  copies;
        logic [7:0]  deps;
        logic [7:0]  args;
        logic [7:0]  pad;
    } spawn_header_t;

    // Any queue word, decoded as a header only at word 0
    typedef union packed {
        spawn_header_t hdr;
        logic [63:0]   raw;
    } queue_word_u;

endpackage

`default_nettype wire

// File: spawn_writer/spawn_queue_writer.sv
// Owns queue port A; the header is always the last word written, payload words wait on in_valid
`timescale 1ns/1ps
`default_nettype none

module spawn_queue_writer (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        job_valid,
    input  wire logic [63:0] job_task_id,
    input  wire logic [63:0] job_parent_id,
    input  wire logic [63:0] job_type_word,
    input  wire logic [11:0] job_counts,
    input  wire logic [4:0]  payload_len,
    input  wire logic        too_long,
    input  wire logic        in_valid,
    input  wire logic [63:0] in_data,
    input  wire logic [63:0] queue_dout,
    output logic             in_ready,
    output logic             queue_en,
    output logic [7:0]       queue_we,
    output logic [31:0]      queue_addr,
    output logic [63:0]      queue_din,
    output logic             done,
    output logic             accepted
);

    logic [2:0]                             state;
    logic [spawnout_pkg::slot_idx_bits-1:0] slot_ptr;
    logic [3:0]                             word_idx;
    logic                                   reject;
    logic                                   last_payload;
    spawnout_pkg::queue_word_u              slot_word;
    spawnout_pkg::queue_word_u              hdr_word;

    function automatic logic [31:0] word_addr(
        input logic [spawnout_pkg::slot_idx_bits-1:0] slot,
        input logic [3:0]                             word
    );
        word_addr = 32'(slot) * 32'(spawnout_pkg::slot_bytes)
                  + 32'(word) * 32'(spawnout_pkg::word_bytes);
    endfunction

    // Header read back during the check state
    assign slot_word.raw = queue_dout;
    assign reject        = too_long || slot_word.hdr.valid;
    assign last_payload  = ({1'b0, word_idx} == payload_len - 5'd1);

    always_comb begin
        hdr_word.raw        = '0;
        hdr_word.hdr.valid  = 1'b1;
        hdr_word.hdr.args   = {4'b0000, job_counts[3:0]};
        hdr_word.hdr.deps   = {4'b0000, job_counts[7:4]};
        hdr_word.hdr.copies = {4'b0000, job_counts[11:8]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= spawnout_pkg::st_idle;
            slot_ptr <= '0;
            word_idx <= '0;
        end else begin
            case (state)
                spawnout_pkg::st_idle: begin
                    if (job_valid) begin
                        state <= spawnout_pkg::st_check_read;
                    end
                end
                spawnout_pkg::st_check_read: begin
                    state <= spawnout_pkg::st_check;
                end
                spawnout_pkg::st_check: begin
                    word_idx <= '0;
                    if (reject) begin
                        state <= spawnout_pkg::st_idle;
                    end else if (payload_len == 5'd0) begin
                        state <= spawnout_pkg::st_task_id;
                    end else begin
                        state <= spawnout_pkg::st_payload;
                    end
                end
                spawnout_pkg::st_payload: begin
                    if (in_valid) begin
                        word_idx <= word_idx + 4'd1;
                        if (last_payload) begin
                            state <= spawnout_pkg::st_task_id;
                        end
                    end
                end
                spawnout_pkg::st_task_id: begin
                    state <= spawnout_pkg::st_parent_id;
                end
                spawnout_pkg::st_parent_id: begin
                    state <= spawnout_pkg::st_type;
                end
                spawnout_pkg::st_type: begin
                    state <= spawnout_pkg::st_header;
                end
                default: begin
                    // Header written, pointer wraps since the slot count is 2**n
                    slot_ptr <= slot_ptr + 1'b1;
                    state    <= spawnout_pkg::st_idle;
                end
            endcase
        end
    end

    always_comb begin
        in_ready   = 1'b0;
        queue_en   = 1'b0;
        queue_we   = 8'h00;
        queue_addr = word_addr(slot_ptr, spawnout_pkg::word_header);
        queue_din  = '0;
        done       = 1'b0;
        accepted   = 1'b0;
        case (state)
            spawnout_pkg::st_check_read: begin
                queue_en = 1'b1;
            end
            spawnout_pkg::st_check: begin
                done = reject;
            end
            spawnout_pkg::st_payload: begin
                in_ready   = 1'b1;
                queue_en   = in_valid;
                queue_we   = {8{in_valid}};
                queue_addr = word_addr(slot_ptr, spawnout_pkg::word_payload + word_idx);
                queue_din  = in_data;
            end
            spawnout_pkg::st_task_id: begin
                queue_en   = 1'b1;
                queue_we   = 8'hFF;
                queue_addr = word_addr(slot_ptr, spawnout_pkg::word_task_id);
                queue_din  = job_task_id;
            end
            spawnout_pkg::st_parent_id: begin
                queue_en   = 1'b1;
                queue_we   = 8'hFF;
                queue_addr = word_addr(slot_ptr, spawnout_pkg::word_parent_id);
                queue_din  = job_parent_id;
            end
            spawnout_pkg::st_type: begin
                queue_en   = 1'b1;
                queue_we   = 8'hFF;
                queue_addr = word_addr(slot_ptr, spawnout_pkg::word_type);
                queue_din  = job_type_word;
            end
            spawnout_pkg::st_header: begin
                queue_en  = 1'b1;
                queue_we  = 8'hFF;
                queue_din = hdr_word.raw;
                done      = 1'b1;
                accepted  = 1'b1;
            end
            default: begin
                queue_en = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verification/spawnout_properties.sv
// Bound into the queue writer; checks hold only while rst_n is high, failures are counted
`timescale 1ns/1ps
`default_nettype none

module spawnout_properties (
    input wire logic        clk,
    input wire logic        rst_n,
    input wire logic        in_ready,
    input wire logic        queue_en,
    input wire logic [7:0]  queue_we,
    input wire logic [31:0] queue_addr,
    input wire logic        done
);

    int   fail_count = 0;
    logic header_write;

    // Word 0 of any slot sits on a slot boundary
    assign header_write = queue_en && (queue_we != 8'h00)
                       && (queue_addr % 32'(spawnout_pkg::slot_bytes) == 32'd0);

    whole_word_we: assert property (@(posedge clk) disable iff (!rst_n)
        (queue_we == 8'h00) || (queue_we == 8'hFF))
    else begin
        $error("queue_we enables only part of a word");
        fail_count++;
    end

    ready_not_with_header: assert property (@(posedge clk) disable iff (!rst_n)
        !(in_ready && header_write))
    else begin
        $error("in_ready is high during a header write");
        fail_count++;
    end

    // A done pulse is a single cycle
    done_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
    else begin
        $error("done stayed high for two cycles");
        fail_count++;
    end

endmodule

bind spawn_queue_writer spawnout_properties u_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_ready   (in_ready),
    .queue_en   (queue_en),
    .queue_we   (queue_we),
    .queue_addr (queue_addr),
    .done       (done)
);

`default_nettype wire

// File: verification/spawnout_tb.sv
// One request at a time; port B plays the consumer and clears every header after reset
`timescale 1ns/1ps
`default_nettype none

module spawnout_tb;

    localparam int wait_limit = 400;

    logic        clk;
    logic        rst_n;
    logic        spawn_start;
    logic [63:0] task_id;
    logic [63:0] parent_task_id;
    logic [31:0] task_type;
    logic [1:0]  task_arch;
    logic [3:0]  num_args;
    logic [3:0]  num_deps;
    logic [3:0]  num_cops;
    logic        in_valid;
    logic [63:0] in_data;
    logic        cons_en;
    logic [7:0]  cons_we;
    logic [31:0] cons_addr;
    logic [63:0] cons_din;
    logic        busy;
    logic        in_ready;
    logic [1:0]  spawn_ret;
    logic [15:0] spawned_count;
    logic [15:0] rejected_count;
    logic [63:0] cons_dout;

    // Queue model and response bookkeeping
    bit          occupied [spawnout_pkg::queue_slots];
    int          model_ptr;
    int          ok_tally;
    int          reject_tally;
    int          req_count;
    int          ret_count;
    logic [1:0]  exp_ret;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    spawnout_top u_spawnout_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .spawn_start    (spawn_start),
        .task_id        (task_id),
        .parent_task_id (parent_task_id),
        .task_type      (task_type),
        .task_arch      (task_arch),
        .num_args       (num_args),
        .num_deps       (num_deps),
        .num_cops       (num_cops),
        .in_valid       (in_valid),
        .in_data        (in_data),
        .cons_en        (cons_en),
        .cons_we        (cons_we),
        .cons_addr      (cons_addr),
        .cons_din       (cons_din),
        .busy           (busy),
        .in_ready       (in_ready),
        .spawn_ret      (spawn_ret),
        .spawned_count  (spawned_count),
        .rejected_count (rejected_count),
        .cons_dout      (cons_dout)
    );

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("ERROR at %0d ns: %s expected %h, got %h",
                               $time, name, expected, actual));
        end
    endtask

    function automatic logic [31:0] word_address(input int slot, input int word);
        return 32'(slot * spawnout_pkg::slot_bytes + word * spawnout_pkg::word_bytes);
    endfunction

    // Expected slot image in slot word order
    function automatic logic [15:0][63:0] expected_slot(
        input logic [63:0]       tid,
        input logic [63:0]       pid,
        input logic [31:0]       ttype,
        input logic [1:0]        arch,
        input logic [3:0]        args,
        input logic [3:0]        deps,
        input logic [3:0]        cops,
        input logic [11:0][63:0] payload
    );
        logic [15:0][63:0] img;
        int                len;
        int                i;
        img    = '0;
        len    = int'(args) + int'(deps) + int'(cops);
        img[0] = {1'b1, 31'd0, 4'd0, cops, 4'd0, deps, 4'd0, args, 8'd0};
        img[1] = tid;
        img[2] = pid;
        img[3] = {30'd0, arch, ttype};
        for (i = 0; i < len; i++) begin
            img[4 + i] = payload[i];
        end
        return img;
    endfunction

    task automatic read_word(input logic [31:0] addr, output logic [63:0] data);
        @(negedge clk);
        cons_en   = 1'b1;
        cons_we   = 8'h00;
        cons_addr = addr;
        @(negedge clk);
        cons_en   = 1'b0;
        data      = cons_dout;
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [63:0] data);
        @(negedge clk);
        cons_en   = 1'b1;
        cons_we   = 8'hFF;
        cons_addr = addr;
        cons_din  = data;
        @(negedge clk);
        cons_en   = 1'b0;
        cons_we   = 8'h00;
    endtask

    // Words go out only while in_ready is high and with random gaps
    task automatic stream_payload(input logic [11:0][63:0] payload, input int len);
        int idx;
        int stall;
        idx   = 0;
        stall = 0;
        while (idx < len) begin
            @(negedge clk);
            if (in_ready && ($urandom % 4 != 0)) begin
                in_valid = 1'b1;
                in_data  = payload[idx];
                idx++;
                stall    = 0;
            end else begin
                in_valid = 1'b0;
                stall++;
                if (stall > wait_limit) begin
                    fail_run("in_ready stayed low while payload words were pending");
                end
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic wait_response;
        int cycles;
        cycles = 0;
        while (ret_count != req_count) begin
            @(posedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_run("no return code arrived for the pending spawn request");
            end
        end
    endtask

    task automatic wait_idle;
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_run("busy did not fall after the return code");
            end
        end while (busy);
    endtask

    task automatic verify_slot(input int slot, input int len, input logic [15:0][63:0] image);
        spawnout_pkg::queue_word_u got_hdr;
        spawnout_pkg::queue_word_u exp_hdr;
        logic [63:0]               got;
        int                        w;
        for (w = 0; w < 4 + len; w++) begin
            read_word(word_address(slot, w), got);
            if (w == 0) begin
                got_hdr.raw = got;
                exp_hdr.raw = image[0];
                check_value("header.valid", 64'(exp_hdr.hdr.valid), 64'(got_hdr.hdr.valid));
                check_value("header.copies", 64'(exp_hdr.hdr.copies), 64'(got_hdr.hdr.copies));
                check_value("header.deps", 64'(exp_hdr.hdr.deps), 64'(got_hdr.hdr.deps));
                check_value("header.args", 64'(exp_hdr.hdr.args), 64'(got_hdr.hdr.args));
            end
            check_value($sformatf("slot %0d word %0d", slot, w), image[w], got);
        end
    endtask

    task automatic spawn_request(input logic [3:0] args, input logic [3:0] deps,
                                 input logic [3:0] cops);
        logic [63:0]       tid;
        logic [63:0]       pid;
        logic [31:0]       ttype;
        logic [1:0]        arch;
        logic [11:0][63:0] payload;
        int                len;
        int                slot;
        bit                fits;
        int                i;
        tid   = {$urandom, $urandom};
        pid   = {$urandom, $urandom};
        ttype = $urandom;
        arch  = 2'($urandom % 4);
        for (i = 0; i < spawnout_pkg::max_payload; i++) begin
            payload[i] = {$urandom, $urandom};
        end
        len  = int'(args) + int'(deps) + int'(cops);
        slot = model_ptr;
        // Too many words or a still valid slot both end in reject
        fits    = (len <= spawnout_pkg::max_payload) && !occupied[slot];
        exp_ret = fits ? spawnout_pkg::ret_ok : spawnout_pkg::ret_reject;
        @(negedge clk);
        task_id        = tid;
        parent_task_id = pid;
        task_type      = ttype;
        task_arch      = arch;
        num_args       = args;
        num_deps       = deps;
        num_cops       = cops;
        spawn_start    = 1'b1;
        req_count++;
        @(negedge clk);
        spawn_start = 1'b0;
        if (fits && len > 0) begin
            stream_payload(payload, len);
        end
        wait_response();
        wait_idle();
        if (fits) begin
            ok_tally++;
            occupied[slot] = 1'b1;
            model_ptr      = (model_ptr + 1) % spawnout_pkg::queue_slots;
            verify_slot(slot, len, expected_slot(tid, pid, ttype, arch, args, deps, cops,
                                                 payload));
        end else begin
            reject_tally++;
        end
    endtask

    task automatic spawn_fitting;
        spawn_request(4'($urandom % 5), 4'($urandom % 5), 4'($urandom % 5));
    endtask

    // Compares every return code pulse against the prediction
    always @(negedge clk) begin
        if (rst_n === 1'b1 && spawn_ret !== spawnout_pkg::ret_wait) begin
            if (ret_count == req_count) begin
                fail_run("spawn_ret pulsed with no spawn request pending");
            end else begin
                check_value("spawn_ret", 64'(exp_ret), 64'(spawn_ret));
                ret_count++;
            end
        end
    end

    initial begin
        int          s;
        int          cycles;
        logic [63:0] got;
        void'($urandom(53221));
        spawn_start    = 1'b0;
        task_id        = '0;
        parent_task_id = '0;
        task_type      = '0;
        task_arch      = '0;
        num_args       = '0;
        num_deps       = '0;
        num_cops       = '0;
        in_valid       = 1'b0;
        in_data        = '0;
        cons_en        = 1'b0;
        cons_we        = 8'h00;
        cons_addr      = '0;
        cons_din       = '0;
        exp_ret        = spawnout_pkg::ret_wait;
        cycles         = 0;
        while (rst_n !== 1'b1) begin
            @(negedge clk);
            cycles++;
            if (cycles > wait_limit) begin
                fail_run("reset was never released");
            end
        end

        check_value("spawn_ret", 64'(spawnout_pkg::ret_wait), 64'(spawn_ret));
        check_value("busy", 64'd0, 64'(busy));
        check_value("in_ready", 64'd0, 64'(in_ready));
        check_value("spawned_count", 64'd0, 64'(spawned_count));
        check_value("rejected_count", 64'd0, 64'(rejected_count));

        // Memory powers up unknown
        for (s = 0; s < spawnout_pkg::queue_slots; s++) begin
            write_word(word_address(s, 0), 64'd0);
        end

        repeat (20) spawn_fitting();

        // Oversized requests leave the next slot untouched
        for (s = 0; s < 3; s++) begin
            spawn_request(4'(4 + $urandom % 12), 4'(4 + $urandom % 12), 4'(5 + $urandom % 11));
            read_word(word_address(model_ptr, 0), got);
            check_value("header of the next slot after a reject", 64'd0, got);
            spawn_fitting();
        end

        while (ok_tally < spawnout_pkg::queue_slots) begin
            spawn_fitting();
        end
        // Queue is full here and the consumer then releases slot 0
        spawn_fitting();
        write_word(word_address(0, 0), 64'd0);
        occupied[0] = 1'b0;
        spawn_fitting();

        check_value("spawned_count", 64'(ok_tally), 64'(spawned_count));
        check_value("rejected_count", 64'(reject_tally), 64'(rejected_count));

        if (u_spawnout_top.u_writer.u_props.fail_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run("an assertion on the writer's queue port failed");
        end
    end

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
// Free-running 40 ns clock; reset is low for four rising edges and released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    localparam int half_period = 20;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verilog/spawn_decode.sv
// Holds one request until done; a start strobe while busy is high is dropped silently
`timescale 1ns/1ps
`default_nettype none

module spawn_decode (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   spawn_start,
    input  wire logic [63:0]                            task_id,
    input  wire logic [63:0]                            parent_task_id,
    input  wire logic [spawnout_pkg::tasktype_bits-1:0] task_type,
    input  wire logic [spawnout_pkg::archbits_bits-1:0] task_arch,
    input  wire logic [3:0]                             num_args,
    input  wire logic [3:0]                             num_deps,
    input  wire logic [3:0]                             num_cops,
    input  wire logic                                   done,
    output logic                                        busy,
    output logic                                        job_valid,
    output logic [63:0]                                 job_task_id,
    output logic [63:0]                                 job_parent_id,
    output logic [63:0]                                 job_type_word,
    output logic [11:0]                                 job_counts,
    output logic [4:0]                                  payload_len,
    output logic                                        too_long
);

    localparam int type_pad_bits =
        64 - spawnout_pkg::tasktype_bits - spawnout_pkg::archbits_bits;

    logic       take;
    logic [5:0] count_sum;

    assign take = spawn_start && !busy;

    // Up to 45 words can be asked for, so the sum needs six bits
    assign count_sum = {2'b00, num_args} + {2'b00, num_deps} + {2'b00, num_cops};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            job_valid <= 1'b0;
        end else begin
            job_valid <= take;
            if (take) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    // Fields stay stable for the writer until the next accepted start
    always_ff @(posedge clk) begin
        if (take) begin
            job_task_id   <= task_id;
            job_parent_id <= parent_task_id;
            job_type_word <= {{type_pad_bits{1'b0}}, task_arch, task_type};
            // Packed as cops, deps, args from the top
            job_counts    <= {num_cops, num_deps, num_args};
            payload_len   <= count_sum[4:0];
            too_long      <= count_sum > 6'(spawnout_pkg::max_payload);
        end
    end

endmodule

`default_nettype wire

// File: verilog/spawn_queue_ram.sv
// Contents are not reset, so headers must be cleared before use; reads return the old word
`timescale 1ns/1ps
`default_nettype none

module spawn_queue_ram (
    input  wire logic        clk,
    input  wire logic        a_en,
    input  wire logic [7:0]  a_we,
    input  wire logic [31:0] a_addr,
    input  wire logic [63:0] a_din,
    output logic      [63:0] a_dout,
    input  wire logic        b_en,
    input  wire logic [7:0]  b_we,
    input  wire logic [31:0] b_addr,
    input  wire logic [63:0] b_din,
    output logic      [63:0] b_dout
);

    localparam int idx_top = spawnout_pkg::queue_idx_bits + 2;

    logic [63:0]                             mem [spawnout_pkg::queue_words];
    logic [spawnout_pkg::queue_idx_bits-1:0] a_idx;
    logic [spawnout_pkg::queue_idx_bits-1:0] b_idx;

    // Byte addresses, low three bits select a byte inside the word
    assign a_idx = a_addr[idx_top:3];
    assign b_idx = b_addr[idx_top:3];

    always @(posedge clk) begin
        if (a_en) begin
            a_dout <= mem[a_idx];
            for (int i = 0; i < 8; i++) begin
                if (a_we[i]) begin
                    mem[a_idx][i*8 +: 8] <= a_din[i*8 +: 8];
                end
            end
        end
    end

    // Consumer side
    always @(posedge clk) begin
        if (b_en) begin
            b_dout <= mem[b_idx];
            for (int i = 0; i < 8; i++) begin
                if (b_we[i]) begin
                    mem[b_idx][i*8 +: 8] <= b_din[i*8 +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/spawn_result.sv
// Return code lasts exactly one cycle after done; the counters wrap at 16 bits
`timescale 1ns/1ps
`default_nettype none

module spawn_result (
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  done,
    input  wire logic  accepted,
    output logic [1:0] spawn_ret,
    output logic [15:0] spawned_count,
    output logic [15:0] rejected_count
);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            spawn_ret      <= spawnout_pkg::ret_wait;
            spawned_count  <= '0;
            rejected_count <= '0;
        end else begin
            spawn_ret <= spawnout_pkg::ret_wait;
            if (done) begin
                if (accepted) begin
                    spawn_ret     <= spawnout_pkg::ret_ok;
                    spawned_count <= spawned_count + 16'd1;
                end else begin
                    spawn_ret      <= spawnout_pkg::ret_reject;
                    rejected_count <= rejected_count + 16'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/spawnout_top.sv
// One request in flight at a time; the consumer must only touch valid slots on port B
`timescale 1ns/1ps
`default_nettype none

module spawnout_top (
    input  wire logic                                   clk,
    input  wire logic                                   rst_n,
    input  wire logic                                   spawn_start,
    input  wire logic [63:0]                            task_id,
    input  wire logic [63:0]                            parent_task_id,
    input  wire logic [spawnout_pkg::tasktype_bits-1:0] task_type,
    input  wire logic [spawnout_pkg::archbits_bits-1:0] task_arch,
    input  wire logic [3:0]                             num_args,
    input  wire logic [3:0]                             num_deps,
    input  wire logic [3:0]                             num_cops,
    input  wire logic                                   in_valid,
    input  wire logic [63:0]                            in_data,
    input  wire logic                                   cons_en,
    input  wire logic [7:0]                             cons_we,
    input  wire logic [31:0]                            cons_addr,
    input  wire logic [63:0]                            cons_din,
    output logic                                        busy,
    output logic                                        in_ready,
    output logic [1:0]                                  spawn_ret,
    output logic [15:0]                                 spawned_count,
    output logic [15:0]                                 rejected_count,
    output logic [63:0]                                 cons_dout
);

    logic        job_valid;
    logic [63:0] job_task_id;
    logic [63:0] job_parent_id;
    logic [63:0] job_type_word;
    logic [11:0] job_counts;
    logic [4:0]  payload_len;
    logic        too_long;
    logic        done;
    logic        accepted;

    // Writer side of the queue memory
    logic        queue_en;
    logic [7:0]  queue_we;
    logic [31:0] queue_addr;
    logic [63:0] queue_din;
    logic [63:0] queue_dout;

    spawn_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .spawn_start    (spawn_start),
        .task_id        (task_id),
        .parent_task_id (parent_task_id),
        .task_type      (task_type),
        .task_arch      (task_arch),
        .num_args       (num_args),
        .num_deps       (num_deps),
        .num_cops       (num_cops),
        .done           (done),
        .busy           (busy),
        .job_valid      (job_valid),
        .job_task_id    (job_task_id),
        .job_parent_id  (job_parent_id),
        .job_type_word  (job_type_word),
        .job_counts     (job_counts),
        .payload_len    (payload_len),
        .too_long       (too_long)
    );

    spawn_queue_writer u_writer (
        .clk           (clk),
        .rst_n         (rst_n),
        .job_valid     (job_valid),
        .job_task_id   (job_task_id),
        .job_parent_id (job_parent_id),
        .job_type_word (job_type_word),
        .job_counts    (job_counts),
        .payload_len   (payload_len),
        .too_long      (too_long),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .queue_dout    (queue_dout),
        .in_ready      (in_ready),
        .queue_en      (queue_en),
        .queue_we      (queue_we),
        .queue_addr    (queue_addr),
        .queue_din     (queue_din),
        .done          (done),
        .accepted      (accepted)
    );

    spawn_result u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .done           (done),
        .accepted       (accepted),
        .spawn_ret      (spawn_ret),
        .spawned_count  (spawned_count),
        .rejected_count (rejected_count)
    );

    spawn_queue_ram u_ram (
        .clk    (clk),
        .a_en   (queue_en),
        .a_we   (queue_we),
        .a_addr (queue_addr),
        .a_din  (queue_din),
        .a_dout (queue_dout),
        .b_en   (cons_en),
        .b_we   (cons_we),
        .b_addr (cons_addr),
        .b_din  (cons_din),
        .b_dout (cons_dout)
    );

endmodule

`default_nettype wire
